// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  - src/fetch_pkg.sv
  - src/cache_way.sv
  - src/way_merge.sv
  - src/icache_ctrl.sv
  - src/if_stage.sv
  - src/fetch_top.sv
  - target: test
    files:
      - test/tb_imem.sv
      - test/tb_fetch_top.sv

// ==== compile.f ====
src/fetch_pkg.sv
src/cache_way.sv
src/way_merge.sv
src/icache_ctrl.sv
src/if_stage.sv
src/fetch_top.sv
test/tb_imem.sv
test/tb_fetch_top.sv

// ==== src/cache_way.sv ====
`timescale 1ns/10ps

module cache_way #(
	parameter int NUM_SETS = 16
) (
	input  logic                      clk_i,
	input  logic                      rst_ni,
	input  fetch_pkg::addr_t          pc_i,
	input  logic                      fill_i,
	input  fetch_pkg::line_t          fill_line_i,
	output fetch_pkg::way_lookup_t    lookup_o
);

	localparam int ADDR_BITS  = $bits(fetch_pkg::addr_t);
	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS   = ADDR_BITS - fetch_pkg::LINE_OFFSET_BITS - INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0]   tag_t;

	logic [NUM_SETS-1:0] valid_q;
	tag_t                tag_q [NUM_SETS];
	fetch_pkg::line_t    line_q [NUM_SETS];

	index_t index;
	tag_t   tag;

	// split the pc into set index and tag
	assign index = pc_i[fetch_pkg::LINE_OFFSET_BITS +: INDEX_BITS];
	assign tag   = pc_i[ADDR_BITS-1 -: TAG_BITS];

	// combinational lookup of the indexed set
	assign lookup_o.hit  = valid_q[index] && (tag_q[index] == tag);
	assign lookup_o.data = line_q[index];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= '0;
		end else if (fill_i) begin
			valid_q[index] <= 1'b1;
		end
	end

	// tag and line storage
	always_ff @(posedge clk_i) begin
		if (fill_i) begin
			tag_q[index]  <= tag;
			line_q[index] <= fill_line_i;
		end
	end

endmodule

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

	// byte address and instruction word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;

	// one cache line holds four instruction words
	typedef logic [127:0] line_t;

	// statistics counter
	typedef logic [31:0] cnt_t;

	// byte offset inside a line, tied to the width of line_t
	parameter int LINE_OFFSET_BITS = 4;

	// next-pc source chosen by the execute stage
	typedef enum logic [1:0] {
		REDIR_NONE    = 2'd0,
		REDIR_MISPRED = 2'd1,
		REDIR_ALU     = 2'd2
	} redirect_e;

	// icache miss controller states
	typedef enum logic {
		ST_LOOKUP = 1'b0,
		ST_FILL   = 1'b1
	} ctrl_state_e;

	// line refill request, held until ready
	typedef struct packed {
		logic  valid;
		addr_t addr;
	} mem_req_t;

	// single-cycle answer from memory
	typedef struct packed {
		logic  ready;
		line_t data;
	} mem_rsp_t;

	// one way's answer to the way merge
	typedef struct packed {
		logic  hit;
		line_t data;
	} way_lookup_t;

endpackage

// ==== src/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top #(
	parameter int NUM_WAYS = 2,
	parameter int NUM_SETS = 16
) (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  bp_hit_i,
	input  fetch_pkg::addr_t      bp_target_i,
	input  fetch_pkg::redirect_e  redirect_i,
	input  fetch_pkg::addr_t      mispred_pc_i,
	input  fetch_pkg::addr_t      alu_pc_i,
	input  logic                  pc_en_i,
	input  logic                  id_en_i,
	input  logic                  flush_i,
	input  fetch_pkg::mem_rsp_t   mem_rsp_i,
	output fetch_pkg::addr_t      pc_bp_o,
	output fetch_pkg::addr_t      pc_d_o,
	output fetch_pkg::addr_t      pc4_d_o,
	output fetch_pkg::inst_t      inst_d_o,
	output logic                  bp_hit_d_o,
	output logic                  stall_o,
	output fetch_pkg::mem_req_t   mem_req_o,
	output fetch_pkg::cnt_t       no_acc_o,
	output fetch_pkg::cnt_t       no_hit_o,
	output fetch_pkg::cnt_t       no_miss_o
);

	fetch_pkg::addr_t       pc;
	fetch_pkg::inst_t       inst;
	logic                   hit;
	logic                   stall;
	logic [NUM_WAYS-1:0]    fill;
	fetch_pkg::line_t       fill_line;
	fetch_pkg::way_lookup_t lookups [NUM_WAYS];

	if_stage i_if_stage (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.bp_hit_i     (bp_hit_i),
		.bp_target_i  (bp_target_i),
		.redirect_i   (redirect_i),
		.mispred_pc_i (mispred_pc_i),
		.alu_pc_i     (alu_pc_i),
		.pc_en_i      (pc_en_i),
		.id_en_i      (id_en_i),
		.flush_i      (flush_i),
		.stall_i      (stall),
		.inst_i       (inst),
		.pc_o         (pc),
		.pc_d_o       (pc_d_o),
		.pc4_d_o      (pc4_d_o),
		.inst_d_o     (inst_d_o),
		.bp_hit_d_o   (bp_hit_d_o)
	);

	icache_ctrl #(
		.NUM_WAYS (NUM_WAYS),
		.NUM_SETS (NUM_SETS)
	) i_icache_ctrl (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.pc_i        (pc),
		.hit_i       (hit),
		.mem_rsp_i   (mem_rsp_i),
		.mem_req_o   (mem_req_o),
		.fill_o      (fill),
		.fill_line_o (fill_line),
		.stall_o     (stall),
		.no_acc_o    (no_acc_o),
		.no_hit_o    (no_hit_o),
		.no_miss_o   (no_miss_o)
	);

	// identical ways, each with its own fill strobe
	for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
		cache_way #(
			.NUM_SETS (NUM_SETS)
		) i_cache_way (
			.clk_i       (clk_i),
			.rst_ni      (rst_ni),
			.pc_i        (pc),
			.fill_i      (fill[w]),
			.fill_line_i (fill_line),
			.lookup_o    (lookups[w])
		);
	end

	way_merge #(
		.NUM_WAYS (NUM_WAYS)
	) i_way_merge (
		.lookups_i (lookups),
		.pc_i      (pc),
		.hit_o     (hit),
		.inst_o    (inst)
	);

	assign pc_bp_o = pc;
	assign stall_o = stall;

endmodule

// ==== src/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl #(
	parameter int NUM_WAYS = 2,
	parameter int NUM_SETS = 16
) (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  fetch_pkg::addr_t     pc_i,
	input  logic                 hit_i,
	input  fetch_pkg::mem_rsp_t  mem_rsp_i,
	output fetch_pkg::mem_req_t  mem_req_o,
	output logic [NUM_WAYS-1:0]  fill_o,
	output fetch_pkg::line_t     fill_line_o,
	output logic                 stall_o,
	output fetch_pkg::cnt_t      no_acc_o,
	output fetch_pkg::cnt_t      no_hit_o,
	output fetch_pkg::cnt_t      no_miss_o
);

	localparam int ADDR_BITS  = $bits(fetch_pkg::addr_t);
	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int WAY_BITS   = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [WAY_BITS-1:0]   way_t;

	fetch_pkg::ctrl_state_e state_q;
	fetch_pkg::ctrl_state_e state_d;

	// round-robin victim pointer per set
	way_t rr_q [NUM_SETS];

	index_t          index;
	way_t            victim;
	logic            refill_done;
	fetch_pkg::cnt_t acc_q;
	fetch_pkg::cnt_t hit_q;
	fetch_pkg::cnt_t miss_q;

	assign index       = pc_i[fetch_pkg::LINE_OFFSET_BITS +: INDEX_BITS];
	assign victim      = rr_q[index];
	assign refill_done = (state_q == fetch_pkg::ST_FILL) && mem_rsp_i.ready;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			fetch_pkg::ST_LOOKUP: begin
				if (!hit_i) begin
					state_d = fetch_pkg::ST_FILL;
				end
			end
			fetch_pkg::ST_FILL: begin
				if (mem_rsp_i.ready) begin
					state_d = fetch_pkg::ST_LOOKUP;
				end
			end
			default: begin
				state_d = fetch_pkg::ST_LOOKUP;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= fetch_pkg::ST_LOOKUP;
		end else begin
			state_q <= state_d;
		end
	end

	// a miss stalls in the same cycle, the fill stalls until ready
	assign stall_o = (state_q == fetch_pkg::ST_FILL) || !hit_i;

	// line-aligned request, held for the whole fill
	assign mem_req_o.valid = (state_q == fetch_pkg::ST_FILL);
	assign mem_req_o.addr  = {pc_i[ADDR_BITS-1:fetch_pkg::LINE_OFFSET_BITS],
		{fetch_pkg::LINE_OFFSET_BITS{1'b0}}};

	// write strobe for the victim way only
	always_comb begin
		fill_o = '0;
		if (refill_done) begin
			fill_o[victim] = 1'b1;
		end
	end

	assign fill_line_o = mem_rsp_i.data;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				rr_q[s] <= '0;
			end
		end else if (refill_done) begin
			if (victim == way_t'(NUM_WAYS - 1)) begin
				rr_q[index] <= '0;
			end else begin
				rr_q[index] <= victim + 1'b1;
			end
		end
	end

	// every lookup cycle is an access, counted as hit or miss
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			acc_q  <= '0;
			hit_q  <= '0;
			miss_q <= '0;
		end else if (state_q == fetch_pkg::ST_LOOKUP) begin
			acc_q <= acc_q + 1'b1;
			if (hit_i) begin
				hit_q <= hit_q + 1'b1;
			end else begin
				miss_q <= miss_q + 1'b1;
			end
		end
	end

	assign no_acc_o  = acc_q;
	assign no_hit_o  = hit_q;
	assign no_miss_o = miss_q;

endmodule

// ==== src/if_stage.sv ====
`timescale 1ns/10ps

module if_stage (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  bp_hit_i,
	input  fetch_pkg::addr_t      bp_target_i,
	input  fetch_pkg::redirect_e  redirect_i,
	input  fetch_pkg::addr_t      mispred_pc_i,
	input  fetch_pkg::addr_t      alu_pc_i,
	input  logic                  pc_en_i,
	input  logic                  id_en_i,
	input  logic                  flush_i,
	input  logic                  stall_i,
	input  fetch_pkg::inst_t      inst_i,
	output fetch_pkg::addr_t      pc_o,
	output fetch_pkg::addr_t      pc_d_o,
	output fetch_pkg::addr_t      pc4_d_o,
	output fetch_pkg::inst_t      inst_d_o,
	output logic                  bp_hit_d_o
);

	fetch_pkg::addr_t pc_q;
	fetch_pkg::addr_t pc_plus4;
	fetch_pkg::addr_t pc_next;

	fetch_pkg::addr_t pc_d_q;
	fetch_pkg::addr_t pc4_d_q;
	fetch_pkg::inst_t inst_d_q;
	logic             bp_hit_d_q;

	assign pc_plus4 = pc_q + 32'd4;

	// execute redirects win over the predictor
	always_comb begin
		unique case (redirect_i)
			fetch_pkg::REDIR_MISPRED: pc_next = mispred_pc_i;
			fetch_pkg::REDIR_ALU:     pc_next = alu_pc_i;
			default: begin
				if (bp_hit_i) begin
					pc_next = bp_target_i;
				end else begin
					pc_next = pc_plus4;
				end
			end
		endcase
	end

	// pc advances only when the cache is not stalling
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			pc_q <= '0;
		end else if (pc_en_i && !stall_i) begin
			pc_q <= pc_next;
		end
	end

	// if/id register, bubble on flush or cache stall
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			pc_d_q     <= '0;
			pc4_d_q    <= '0;
			inst_d_q   <= '0;
			bp_hit_d_q <= 1'b0;
		end else if (id_en_i) begin
			if (flush_i || stall_i) begin
				pc_d_q     <= '0;
				pc4_d_q    <= '0;
				inst_d_q   <= '0;
				bp_hit_d_q <= 1'b0;
			end else begin
				pc_d_q     <= pc_q;
				pc4_d_q    <= pc_plus4;
				inst_d_q   <= inst_i;
				bp_hit_d_q <= bp_hit_i;
			end
		end
	end

	assign pc_o       = pc_q;
	assign pc_d_o     = pc_d_q;
	assign pc4_d_o    = pc4_d_q;
	assign inst_d_o   = inst_d_q;
	assign bp_hit_d_o = bp_hit_d_q;

endmodule

// ==== src/way_merge.sv ====
`timescale 1ns/10ps

module way_merge #(
	parameter int NUM_WAYS = 2
) (
	input  fetch_pkg::way_lookup_t lookups_i [NUM_WAYS],
	input  fetch_pkg::addr_t       pc_i,
	output logic                   hit_o,
	output fetch_pkg::inst_t       inst_o
);

	localparam int LINE_BITS = $bits(fetch_pkg::line_t);
	localparam int INST_BITS = $bits(fetch_pkg::inst_t);
	localparam int SEL_BITS  = fetch_pkg::LINE_OFFSET_BITS - 2;

	fetch_pkg::line_t    line;
	logic [SEL_BITS-1:0] word_sel;

	// at most one way hits, so an and-or mux is enough
	always_comb begin
		hit_o = 1'b0;
		line  = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_o = hit_o | lookups_i[w].hit;
			line  = line | ({LINE_BITS{lookups_i[w].hit}} & lookups_i[w].data);
		end
	end

	// word within the line from pc bits 3:2
	assign word_sel = pc_i[fetch_pkg::LINE_OFFSET_BITS-1:2];
	assign inst_o   = line[word_sel*INST_BITS +: INST_BITS];

endmodule

// ==== test/tb_fetch_top.sv ====
`timescale 1ns/10ps

module tb_fetch_top;

	localparam int NUM_WAYS   = 2;
	localparam int NUM_SETS   = 16;
	localparam int NUM_ROWS   = 19;
	localparam int RST_CYCLES = 8;
	// miss cycle, longest fill and the hit that follows, with slack
	localparam int MISS_WORST = 10;
	localparam fetch_pkg::inst_t INST_KEY = 32'h5a3c_0f96;

	localparam fetch_pkg::redirect_e NONE = fetch_pkg::REDIR_NONE;
	localparam fetch_pkg::redirect_e MISP = fetch_pkg::REDIR_MISPRED;
	localparam fetch_pkg::redirect_e ALU  = fetch_pkg::REDIR_ALU;

	// one stimulus row, applied for count accepted cycles
	typedef struct packed {
		logic [3:0]           count;
		fetch_pkg::redirect_e redir;
		fetch_pkg::addr_t     mis_pc;
		fetch_pkg::addr_t     alu_pc;
		logic                 bp_hit;
		fetch_pkg::addr_t     bp_target;
		logic                 flush;
		logic                 pc_en;
		logic                 id_en;
	} row_t;

	logic                 clk;
	logic                 rst_n;
	logic                 bp_hit;
	fetch_pkg::addr_t     bp_target;
	fetch_pkg::redirect_e redirect;
	fetch_pkg::addr_t     mispred_pc;
	fetch_pkg::addr_t     alu_pc;
	logic                 pc_en;
	logic                 id_en;
	logic                 flush;
	fetch_pkg::mem_rsp_t  mem_rsp;
	fetch_pkg::mem_req_t  mem_req;
	fetch_pkg::addr_t     pc_bp;
	fetch_pkg::addr_t     pc_d;
	fetch_pkg::addr_t     pc4_d;
	fetch_pkg::inst_t     inst_d;
	logic                 bp_hit_d;
	logic                 stall;
	fetch_pkg::cnt_t      no_acc;
	fetch_pkg::cnt_t      no_hit;
	fetch_pkg::cnt_t      no_miss;

	row_t             rows [NUM_ROWS];
	int unsigned      cycles = 0;
	int unsigned      cycle_limit = 0;

	// reference cache, one line address per set and way
	fetch_pkg::addr_t model_line [NUM_SETS][NUM_WAYS];
	logic             model_valid [NUM_SETS][NUM_WAYS];
	int unsigned      model_rr [NUM_SETS];

	fetch_top #(
		.NUM_WAYS (NUM_WAYS),
		.NUM_SETS (NUM_SETS)
	) i_fetch_top (
		.clk_i        (clk),
		.rst_ni       (rst_n),
		.bp_hit_i     (bp_hit),
		.bp_target_i  (bp_target),
		.redirect_i   (redirect),
		.mispred_pc_i (mispred_pc),
		.alu_pc_i     (alu_pc),
		.pc_en_i      (pc_en),
		.id_en_i      (id_en),
		.flush_i      (flush),
		.mem_rsp_i    (mem_rsp),
		.pc_bp_o      (pc_bp),
		.pc_d_o       (pc_d),
		.pc4_d_o      (pc4_d),
		.inst_d_o     (inst_d),
		.bp_hit_d_o   (bp_hit_d),
		.stall_o      (stall),
		.mem_req_o    (mem_req),
		.no_acc_o     (no_acc),
		.no_hit_o     (no_hit),
		.no_miss_o    (no_miss)
	);

	tb_imem #(
		.INST_KEY (INST_KEY)
	) i_tb_imem (
		.clk_i     (clk),
		.rst_ni    (rst_n),
		.mem_req_i (mem_req),
		.mem_rsp_o (mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("timeout: fetch did not get through the table in %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1, "run aborted");
		end
	end

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic expect_addr(input string name, input fetch_pkg::addr_t got, exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic verify_inst(input string name, input fetch_pkg::inst_t got, exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_count(input string name, input fetch_pkg::cnt_t got, exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	// memory content rule, word address xor key
	function automatic fetch_pkg::inst_t inst_at(input fetch_pkg::addr_t a);
		return {a[31:2], 2'b00} ^ INST_KEY;
	endfunction

	// mispredict, then alu, then predictor, then pc+4
	function automatic fetch_pkg::addr_t next_pc(input row_t r, input fetch_pkg::addr_t pc);
		if (r.redir == MISP) return r.mis_pc;
		if (r.redir == ALU) return r.alu_pc;
		if (r.bp_hit) return r.bp_target;
		return pc + 32'd4;
	endfunction

	// a missing line goes to the set's round-robin victim
	task automatic model_lookup(input fetch_pkg::addr_t a, output logic miss);
		fetch_pkg::addr_t l;
		int               s;
		l    = {a[31:4], 4'b0000};
		s    = int'(a[31:4] % NUM_SETS);
		miss = 1'b1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (model_valid[s][w] && model_line[s][w] == l) begin
				miss = 1'b0;
			end
		end
		if (miss) begin
			model_line[s][model_rr[s]]  = l;
			model_valid[s][model_rr[s]] = 1'b1;
			model_rr[s] = (model_rr[s] + 1) % NUM_WAYS;
		end
	endtask

	initial begin : run
		fetch_pkg::addr_t ref_pc;
		fetch_pkg::addr_t ref_pc_d;
		fetch_pkg::addr_t ref_pc4_d;
		fetch_pkg::inst_t ref_inst_d;
		logic             ref_bp_d;
		logic             stalled;
		logic             first;
		logic             exp_miss;
		int               total;
		int               misses;
		rst_n      = 1'b0;
		bp_hit     = 1'b0;
		bp_target  = '0;
		redirect   = NONE;
		mispred_pc = '0;
		alu_pc     = '0;
		pc_en      = 1'b0;
		id_en      = 1'b0;
		flush      = 1'b0;
		// 0x000, 0x100, 0x200 and 0x300 all land in set 0
		rows[0]  = '{4'd6, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[1]  = '{4'd1, NONE, 32'h0, 32'h0, 1'b1, 32'h40, 1'b0, 1'b1, 1'b1};
		rows[2]  = '{4'd1, ALU, 32'h0, 32'h80, 1'b1, 32'h44, 1'b0, 1'b1, 1'b1};
		rows[3]  = '{4'd1, MISP, 32'h100, 32'h90, 1'b1, 32'h48, 1'b0, 1'b1, 1'b1};
		rows[4]  = '{4'd3, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[5]  = '{4'd1, ALU, 32'h0, 32'h200, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[6]  = '{4'd2, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[7]  = '{4'd1, ALU, 32'h0, 32'h300, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[8]  = '{4'd1, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[9]  = '{4'd1, MISP, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[10] = '{4'd2, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[11] = '{4'd1, ALU, 32'h0, 32'h300, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[12] = '{4'd2, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b1, 1'b1};
		rows[13] = '{4'd3, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b1};
		rows[14] = '{4'd2, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0};
		rows[15] = '{4'd1, MISP, 32'h104, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[16] = '{4'd4, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		rows[17] = '{4'd1, NONE, 32'h0, 32'h0, 1'b1, 32'h2000, 1'b0, 1'b1, 1'b1};
		rows[18] = '{4'd3, NONE, 32'h0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b1};
		total = 0;
		foreach (rows[r]) begin
			total += rows[r].count;
		end
		cycle_limit = RST_CYCLES + total * MISS_WORST + 20;
		for (int s = 0; s < NUM_SETS; s++) begin
			model_rr[s] = 0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				model_valid[s][w] = 1'b0;
			end
		end
		misses     = 0;
		ref_pc     = '0;
		ref_pc_d   = '0;
		ref_pc4_d  = '0;
		ref_inst_d = '0;
		ref_bp_d   = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		foreach (rows[i]) begin
			for (int n = 0; n < rows[i].count; n++) begin
				redirect   <= rows[i].redir;
				mispred_pc <= rows[i].mis_pc;
				alu_pc     <= rows[i].alu_pc;
				bp_hit     <= rows[i].bp_hit;
				bp_target  <= rows[i].bp_target;
				flush      <= rows[i].flush;
				pc_en      <= rows[i].pc_en;
				id_en      <= rows[i].id_en;
				first      = 1'b1;
				// hold the row until a cycle without stall
				do begin
					@(negedge clk);
					expect_addr("pc_bp_o", pc_bp, ref_pc);
					expect_addr("pc_d_o", pc_d, ref_pc_d);
					expect_addr("pc4_d_o", pc4_d, ref_pc4_d);
					verify_inst("inst_d_o", inst_d, ref_inst_d);
					check_flag("bp_hit_d_o", bp_hit_d, ref_bp_d);
					// first cycle at a pc is a lookup, the fill follows a miss
					if (first) begin
						model_lookup(ref_pc, exp_miss);
						check_flag("stall_o", stall, exp_miss);
						if (exp_miss) begin
							misses++;
						end
					end
					check_flag("mem_req_o.valid", mem_req.valid, !first && stall);
					if (mem_req.valid) begin
						expect_addr("mem_req_o.addr", mem_req.addr, {ref_pc[31:4], 4'b0000});
					end
					stalled = stall;
					first   = 1'b0;
					if (rows[i].id_en) begin
						ref_pc_d   = (rows[i].flush || stalled) ? '0 : ref_pc;
						ref_pc4_d  = (rows[i].flush || stalled) ? '0 : ref_pc + 32'd4;
						ref_inst_d = (rows[i].flush || stalled) ? '0 : inst_at(ref_pc);
						ref_bp_d   = (rows[i].flush || stalled) ? 1'b0 : rows[i].bp_hit;
					end
					if (rows[i].pc_en && !stalled) begin
						ref_pc = next_pc(rows[i], ref_pc);
					end
					@(posedge clk);
				end while (stalled);
			end
		end
		@(negedge clk);
		// every accepted cycle is a hitting lookup, each miss adds one lookup
		compare_count("no_hit_o", no_hit, fetch_pkg::cnt_t'(total));
		compare_count("no_miss_o", no_miss, fetch_pkg::cnt_t'(misses));
		compare_count("no_acc_o", no_acc, fetch_pkg::cnt_t'(total + misses));
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== test/tb_imem.sv ====
`timescale 1ns/10ps

module tb_imem #(
	parameter fetch_pkg::inst_t INST_KEY = 32'h0
) (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  fetch_pkg::mem_req_t mem_req_i,
	output fetch_pkg::mem_rsp_t mem_rsp_o
);

	logic [7:0] lfsr_q;
	logic [1:0] wait_q;
	logic       busy_q;

	// x^8 + x^6 + x^5 + x^4 + 1, new bit enters at bit 0
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// each word is its own byte address scrambled by the key
	function automatic fetch_pkg::line_t line_at(input fetch_pkg::addr_t a);
		fetch_pkg::line_t l;
		for (int w = 0; w < 4; w++) begin
			l[w*32 +: 32] = (a + 32'(w * 4)) ^ INST_KEY;
		end
		return l;
	endfunction

	// ready comes 1 to 4 cycles after the request is seen
	always_ff @(posedge clk_i or negedge rst_ni) begin : respond
		logic [7:0] s1;
		logic [7:0] s2;
		if (!rst_ni) begin
			lfsr_q    <= 8'd41;
			wait_q    <= '0;
			busy_q    <= 1'b0;
			mem_rsp_o <= '0;
		end else begin
			mem_rsp_o.ready <= 1'b0;
			if (busy_q) begin
				if (wait_q == 2'd0) begin
					mem_rsp_o.ready <= 1'b1;
					mem_rsp_o.data  <= line_at(mem_req_i.addr);
					busy_q          <= 1'b0;
				end else begin
					wait_q <= wait_q - 1'b1;
				end
			end else if (mem_req_i.valid && !mem_rsp_o.ready) begin
				// two steps, one per delay bit
				s1 = lfsr_step(lfsr_q);
				s2 = lfsr_step(s1);
				wait_q <= {s2[0], s1[0]};
				lfsr_q <= s2;
				busy_q <= 1'b1;
			end
		end
	end

endmodule
